// ==== dv/cpu_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_properties (
    input wire clk,
    input wire reset,
    input wire running,
    input wire ack,
    input wire overrun,
    input wire mem_write                             // ST in this cycle
);

    // Finish is sticky until reset
    ack_sticky: assert property (@(posedge clk) disable iff (reset) ack |=> ack)
        else $error("ack fell without reset");

    overrun_has_ack: assert property (@(posedge clk) disable iff (reset) overrun |-> ack)
        else $error("overrun high while ack low");

    not_both: assert property (@(posedge clk) disable iff (reset) !(running && ack))
        else $error("running and ack high together");

    // NOP word outside a run
    idle_no_store: assert property (@(posedge clk) disable iff (reset)
        !running |-> !mem_write)
        else $error("data memory write while not running");

endmodule

bind cpu_top cpu_properties i_cpu_properties (
    .clk       (clk),
    .reset     (reset),
    .running   (running),
    .ack       (ack),
    .overrun   (overrun),
    .mem_write (ctrl.mem_write)
);

`default_nettype wire

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_tb import cpu_pkg::*; ;

    localparam int CYCLE_LIMIT = 4096;
    localparam int RUN_LIMIT   = CYCLE_LIMIT + 64;       // Per-run wait bound
    localparam int MAX_CYCLES  = 30000;                  // Whole-run watchdog
    localparam int LOOP_N      = 8;                      // Branch loop passes, at most 128

    logic              clk = 1'b0;
    logic              reset;
    logic              start;
    logic              prog_we;
    logic [7:0]        prog_addr;
    instr_u            prog_data;
    logic [DATA_W-1:0] dbg_addr;
    logic              ack;
    logic              overrun;
    logic [DATA_W-1:0] dbg_data;

    instr_u      prog_q [$];                             // Program being built
    int unsigned lcg_state = 62069;
    int          errors = 0;
    int          tests = 0;
    int          cyc = 0;

    cpu_top #(.PC_W(8), .CYCLE_LIMIT(CYCLE_LIMIT)) i_cpu_top (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dbg_addr  (dbg_addr),
        .ack       (ack),
        .overrun   (overrun),
        .dbg_data  (dbg_data)
    );

    always #4 clk = ~clk;                                // 8 ns period

    always @(posedge clk) begin
        cyc++;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout: simulation ran past %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];                         // Upper bits spread better
    endfunction

    function automatic instr_u enc_li(input logic [7:0] v);
        instr_u w;
        w.i.fmt = 1'b1;
        w.i.imm = v;
        return w;
    endfunction

    function automatic instr_u enc_r(input opcode_e op, input logic [1:0] ra,
                                     input logic [1:0] rb);
        instr_u w;
        w.r.fmt    = 1'b0;
        w.r.opcode = op;
        w.r.ra     = ra;
        w.r.rb     = rb;
        w.r.spare  = 1'b0;
        return w;
    endfunction

    function automatic instr_u enc_beqz(input logic [3:0] off);
        return enc_r(BEQZ, off[3:2], off[1:0]);           // ra holds the high half
    endfunction

    // rx <= v by way of mem[v], which is left holding v
    task automatic emit_set_reg(input logic [7:0] v, input logic [1:0] rx);
        prog_q.push_back(enc_li(v));
        prog_q.push_back(enc_r(ST, 2'd1, 2'd1));
        prog_q.push_back(enc_r(LD, 2'd1, rx));
    endtask

    task automatic load_program();
        foreach (prog_q[k]) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = 8'(k);
            prog_data = prog_q[k];
        end
        @(negedge clk);
        prog_we = 1'b0;
        prog_q.delete();
    endtask

    task automatic reset_dut();
        @(negedge clk);
        reset = 1'b1;
        start = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
    endtask

    // Pulse start and optionally poke a HALT into the program mid-run
    task automatic run_program(input bit poke, output int cycles);
        cycles = 0;
        @(negedge clk) start = 1'b1;
        @(negedge clk) start = 1'b0;
        while (!ack && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            prog_we   = poke && (cycles == 3);
            prog_addr = 8'd20;
            prog_data = enc_r(HALT, 2'd0, 2'd0);
        end
        prog_we = 1'b0;
        if (!ack) begin
            $display("ERROR: run did not raise ack within %0d cycles", RUN_LIMIT);
            errors++;
        end
    endtask

    task automatic read_mem(input logic [7:0] a, output logic [7:0] d);
        @(negedge clk) dbg_addr = a;
        @(negedge clk) d = dbg_data;                      // Settled between edges
    endtask

    task automatic check_byte(input string name, input logic [7:0] a,
                              input logic [7:0] exp);
        logic [7:0] got;
        read_mem(a, got);
        if (got !== exp) begin
            $display("MISMATCH %s addr %h expected %h actual %h", name, a, exp, got);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("Test %s done, %0d errors", name, errors - err_before);
    endtask

    task automatic test_idle();
        logic [7:0] snap [16];
        logic [7:0] got;
        int e0;
        e0 = errors;
        reset_dut();
        @(negedge clk) start = 1'b1;                      // Held high and never released
        for (int k = 0; k < 16; k++)
            read_mem(8'(k), snap[k]);
        repeat (40) begin
            @(negedge clk);
            if (ack !== 1'b0 || overrun !== 1'b0) begin
                $display("ERROR: ack or overrun rose before start was released");
                errors++;
            end
        end
        for (int k = 0; k < 16; k++) begin
            read_mem(8'(k), got);
            if (got !== snap[k]) begin
                $display("MISMATCH idle expected %h actual %h", snap[k], got);
                errors++;
            end
        end
        finish_test("idle", e0);
    endtask

    task automatic test_arith();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] exp [4];
        opcode_e    ops [4];
        int e0;
        int n;
        e0 = errors;
        a = lcg_next();
        b = lcg_next();
        ops = '{ADD, SUB, AND_OP, XOR_OP};
        exp = '{a + b, a - b, a & b, a ^ b};              // Wraps modulo 256
        reset_dut();
        emit_set_reg(a, 2'd2);
        emit_set_reg(b, 2'd3);
        for (int k = 0; k < 4; k++) begin
            emit_set_reg(8'h10 + 8'(k), 2'd0);           // r0 is the store address
            prog_q.push_back(enc_r(ops[k], 2'd2, 2'd3));
            prog_q.push_back(enc_r(ST, 2'd0, 2'd1));
        end
        prog_q.push_back(enc_r(HALT, 2'd0, 2'd0));
        load_program();
        run_program(1'b0, n);
        for (int k = 0; k < 4; k++)
            check_byte("arith", 8'h10 + 8'(k), exp[k]);
        finish_test("arith", e0);
    endtask

    // Store at 0x20+k, load back into r2, copy to 0x30+k
    task automatic build_copy_program(input logic [7:0] v [3]);
        for (int k = 0; k < 3; k++) begin
            emit_set_reg(8'h20 + 8'(k), 2'd0);
            prog_q.push_back(enc_li(v[k]));
            prog_q.push_back(enc_r(ST, 2'd0, 2'd1));
            prog_q.push_back(enc_r(LD, 2'd0, 2'd2));
            emit_set_reg(8'h30 + 8'(k), 2'd0);
            prog_q.push_back(enc_r(ST, 2'd0, 2'd2));
        end
        prog_q.push_back(enc_r(HALT, 2'd0, 2'd0));
    endtask

    task automatic check_copies(input string name, input logic [7:0] v [3]);
        for (int k = 0; k < 3; k++) begin
            check_byte(name, 8'h20 + 8'(k), v[k]);
            check_byte(name, 8'h30 + 8'(k), v[k]);
        end
    endtask

    task automatic test_load_store();
        logic [7:0] v [3];
        int e0;
        int n;
        e0 = errors;
        for (int k = 0; k < 3; k++)
            v[k] = lcg_next();
        reset_dut();
        build_copy_program(v);
        load_program();
        run_program(1'b0, n);
        check_copies("load_store", v);
        finish_test("load_store", e0);
    endtask

    task automatic test_branch_loop();
        logic [7:0] c;
        int e0;
        int n;
        e0 = errors;
        c = lcg_next();
        if (c < 8'd2)
            c = c + 8'd2;                                // mem[1] holds the counter
        reset_dut();
        emit_set_reg(8'd1, 2'd0);                        // Counter address and step
        emit_set_reg(c, 2'd2);                           // Constant and total address
        emit_set_reg(8'h80, 2'd3);                       // Sign mask ends the loop
        prog_q.push_back(enc_li(8'd0));
        prog_q.push_back(enc_r(ST, 2'd2, 2'd1));          // Total starts at 0
        prog_q.push_back(enc_li(8'(LOOP_N - 1)));
        prog_q.push_back(enc_r(ST, 2'd0, 2'd1));          // Counts down to -1
        prog_q.push_back(enc_r(LD, 2'd2, 2'd1));          // Loop top, r1 = total
        prog_q.push_back(enc_r(ADD, 2'd1, 2'd2));
        prog_q.push_back(enc_r(ST, 2'd2, 2'd1));
        prog_q.push_back(enc_r(LD, 2'd0, 2'd1));          // r1 = counter
        prog_q.push_back(enc_r(SUB, 2'd1, 2'd0));         // Step down by r0
        prog_q.push_back(enc_r(ST, 2'd0, 2'd1));
        prog_q.push_back(enc_r(AND_OP, 2'd1, 2'd3));      // Zero until the counter wraps
        prog_q.push_back(enc_beqz(4'b1000));             // Back 8 to loop top
        prog_q.push_back(enc_r(HALT, 2'd0, 2'd0));
        load_program();
        run_program(1'b0, n);
        if (overrun !== 1'b0) begin
            $display("ERROR: loop program raised overrun");
            errors++;
        end
        check_byte("branch_loop", c, 8'(LOOP_N * c));
        finish_test("branch_loop", e0);
    endtask

    task automatic test_overrun();
        int e0;
        int n;
        e0 = errors;
        reset_dut();
        prog_q.push_back(enc_li(8'd0));
        prog_q.push_back(enc_beqz(4'b1111));             // Branch to itself
        load_program();
        run_program(1'b0, n);
        if (overrun !== 1'b1) begin
            $display("MISMATCH overrun expected 1 actual %b", overrun);
            errors++;
        end
        if (n < CYCLE_LIMIT || n > CYCLE_LIMIT + 8) begin
            $display("ERROR: overrun took %0d cycles, limit %0d", n, CYCLE_LIMIT);
            errors++;
        end
        finish_test("overrun", e0);
    endtask

    task automatic test_restart();
        logic [7:0] v [3];
        int e0;
        int n;
        e0 = errors;
        for (int k = 0; k < 3; k++)
            v[k] = lcg_next();
        reset_dut();
        build_copy_program(v);
        load_program();
        run_program(1'b1, n);                            // HALT write must be dropped
        check_copies("ignored_load", v);
        reset_dut();
        if (ack !== 1'b0) begin
            $display("MISMATCH restart_ack expected 0 actual %b", ack);
            errors++;
        end
        run_program(1'b0, n);
        check_copies("restart", v);
        finish_test("restart", e0);
    endtask

    initial begin
        reset     = 1'b1;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_addr  = '0;
        test_idle();
        test_arith();
        test_load_store();
        test_branch_loop();
        test_overrun();
        test_restart();
        $display("Summary: %0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -Mdir obj_dir -f sim.f

out=$(./obj_dir/Vcpu_tb)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

// ==== sim.f ====
src/cpu_pkg.sv
src/run_control.sv
src/program_counter.sv
src/instruction_memory.sv
src/control_decoder.sv
src/register_file.sv
src/execute_unit.sv
src/data_memory.sv
src/cpu_top.sv
dv/cpu_properties.sv
dv/cpu_tb.sv

// ==== src/control_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_decoder import cpu_pkg::*; (
    input  instr_u instr,
    output ctrl_t  ctrl
);

    always_comb begin
        ctrl        = '0;                        // No writes, no branch
        ctrl.alu_op = ADD;
        if (instr.i.fmt) begin                   // Load-immediate view
            ctrl.reg_write = 1'b1;               // Into r1
            ctrl.use_imm   = 1'b1;               // 0 + imm through the ALU
        end else if (!instr.r.spare) begin       // Spare set means no-op
            case (instr.r.opcode)
                ADD, SUB, AND_OP, XOR_OP: begin
                    ctrl.reg_write = 1'b1;       // Result to r1
                    ctrl.alu_op    = instr.r.opcode;
                end
                LD: begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.dest_is_rb = 1'b1;
                    ctrl.mem_read   = 1'b1;      // rb <= mem[ra]
                end
                ST: begin
                    ctrl.mem_write = 1'b1;       // mem[ra] <= rb
                end
                BEQZ: begin
                    ctrl.branch = 1'b1;          // ALU passes r1 for zero test
                end
                HALT: begin
                    ctrl.halt = 1'b1;
                end
                default: begin
                    ctrl = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int DATA_W  = 8;                  // Datapath width
    localparam int INSTR_W = 9;                  // Instruction word width

    // Register-format operations, bits [7:5] of the word
    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND_OP = 3'd2,
        XOR_OP = 3'd3,
        LD     = 3'd4,                           // rb <= mem[ra]
        ST     = 3'd5,                           // mem[ra] <= rb
        BEQZ   = 3'd6,                           // Branch when r1 is zero
        HALT   = 3'd7
    } opcode_e;

    typedef struct packed {
        logic       fmt;                         // 0 for register format
        opcode_e    opcode;
        logic [1:0] ra;                          // Also high half of branch offset
        logic [1:0] rb;                          // Also low half of branch offset
        logic       spare;                       // Must be zero
    } rtype_t;

    typedef struct packed {
        logic              fmt;                  // 1 for load-immediate
        logic [DATA_W-1:0] imm;                  // Goes to r1
    } itype_t;

    // Same 9-bit word, two views selected by bit 8
    typedef union packed {
        rtype_t r;
        itype_t i;
    } instr_u;

    typedef struct packed {
        logic    reg_write;                      // Register write at end of cycle
        logic    dest_is_rb;                     // Destination rb instead of r1
        logic    use_imm;                        // Immediate in place of operands
        logic    mem_read;                       // Write-back from data memory
        logic    mem_write;
        logic    branch;
        logic    halt;
        opcode_e alu_op;
    } ctrl_t;

    localparam logic [1:0] R1_ADDR = 2'd1;       // Fixed ALU and immediate target

    // Register format with spare set, decoded as no operation at all
    localparam instr_u NOP_WORD = 9'b0_000_00_00_1;

endpackage

`default_nettype wire

// ==== src/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int PC_W        = 8,               // Instruction address width
    parameter int CYCLE_LIMIT = 4096             // Run cycles before overrun
) (
    input  logic              clk,
    input  logic              reset,             // Async, active high
    input  logic              start,
    input  logic              prog_we,           // Program load strobe
    input  logic [PC_W-1:0]   prog_addr,
    input  instr_u            prog_data,
    input  logic [DATA_W-1:0] dbg_addr,          // Inspection address
    output logic              ack,
    output logic              overrun,
    output logic [DATA_W-1:0] dbg_data
);

    logic              running;                  // Between release and finish
    logic [PC_W-1:0]   pc;
    instr_u            instr;                    // NOP word when idle
    ctrl_t             ctrl;
    logic              zero;                     // ALU result is zero
    logic [1:0]        waddr;                    // Write-back register
    logic [DATA_W-1:0] wb_value;
    logic [DATA_W-1:0] data_a;
    logic [DATA_W-1:0] data_b;
    logic [DATA_W-1:0] data_r1;
    logic [DATA_W-1:0] mem_addr;                 // Register a as address
    logic [DATA_W-1:0] mem_rdata;

    run_control #(.CYCLE_LIMIT(CYCLE_LIMIT)) i_run_control (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .halt    (ctrl.halt),
        .running (running),
        .ack     (ack),
        .overrun (overrun)
    );

    program_counter #(.PC_W(PC_W)) i_program_counter (
        .clk     (clk),
        .reset   (reset),
        .running (running),
        .branch  (ctrl.branch),
        .zero    (zero),
        .offset  ({instr.r.ra, instr.r.rb}),     // ra is the high half
        .pc      (pc)
    );

    instruction_memory #(.PC_W(PC_W)) i_instruction_memory (
        .clk       (clk),
        .pc        (pc),
        .running   (running),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .instr     (instr)
    );

    control_decoder i_control_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    register_file i_register_file (
        .clk     (clk),
        .reset   (reset),
        .ra      (instr.r.ra),
        .rb      (instr.r.rb),
        .we      (ctrl.reg_write),
        .waddr   (waddr),
        .wdata   (wb_value),
        .data_a  (data_a),
        .data_b  (data_b),
        .data_r1 (data_r1)
    );

    execute_unit i_execute_unit (
        .ctrl      (ctrl),
        .data_a    (data_a),
        .data_b    (data_b),
        .data_r1   (data_r1),
        .imm       (instr.i.imm),
        .mem_rdata (mem_rdata),
        .wb_value  (wb_value),
        .zero      (zero),
        .waddr     (waddr),
        .ra_out    (mem_addr)
    );

    data_memory i_data_memory (
        .clk       (clk),
        .mem_write (ctrl.mem_write),
        .addr      (mem_addr),
        .wdata     (data_b),                     // ST stores register b
        .dbg_addr  (dbg_addr),
        .rdata     (mem_rdata),
        .dbg_data  (dbg_data)
    );

endmodule

`default_nettype wire

// ==== src/data_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_memory import cpu_pkg::*; (
    input  logic              clk,
    input  logic              mem_write,         // ST in this cycle
    input  logic [DATA_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic [DATA_W-1:0] dbg_addr,          // Inspection port
    output logic [DATA_W-1:0] rdata,
    output logic [DATA_W-1:0] dbg_data
);

    localparam int DEPTH = 2 ** DATA_W;          // 256 bytes

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (mem_write)
            mem[addr] <= wdata;                  // Visible after the edge
    end

    // Asynchronous reads for LD and inspection
    assign rdata    = mem[addr];
    assign dbg_data = mem[dbg_addr];

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_unit import cpu_pkg::*; (
    input  ctrl_t             ctrl,
    input  logic [DATA_W-1:0] data_a,
    input  logic [DATA_W-1:0] data_b,
    input  logic [DATA_W-1:0] data_r1,
    input  logic [DATA_W-1:0] imm,               // Low byte of the word
    input  logic [DATA_W-1:0] mem_rdata,
    output logic [DATA_W-1:0] wb_value,
    output logic              zero,
    output logic [1:0]        waddr,             // Destination register
    output logic [DATA_W-1:0] ra_out             // Data memory address
);

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_out;
    instr_u            word_view;                // Low byte read as register format

    // Operand a forced to zero for immediate and branch test
    assign op_a = (ctrl.use_imm || ctrl.branch) ? '0 : data_a;
    assign op_b = ctrl.use_imm ? imm : (ctrl.branch ? data_r1 : data_b);

    always_comb begin
        case (ctrl.alu_op)
            ADD:     alu_out = op_a + op_b;
            SUB:     alu_out = op_a - op_b;      // Wraps modulo 256
            AND_OP:  alu_out = op_a & op_b;
            XOR_OP:  alu_out = op_a ^ op_b;
            default: alu_out = op_a + op_b;
        endcase
    end

    assign zero     = (alu_out == '0);
    assign wb_value = ctrl.mem_read ? mem_rdata : alu_out;  // LD result or ALU

    // rb field lives inside the same low byte
    assign word_view = {1'b0, imm};
    assign waddr     = ctrl.dest_is_rb ? word_view.r.rb : R1_ADDR;
    assign ra_out    = data_a;                   // LD and ST address

endmodule

`default_nettype wire

// ==== src/instruction_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module instruction_memory import cpu_pkg::*; #(
    parameter int PC_W = 8                       // Depth is 2**PC_W words
) (
    input  logic            clk,
    input  logic [PC_W-1:0] pc,
    input  logic            running,
    input  logic            prog_we,             // Load port strobe
    input  logic [PC_W-1:0] prog_addr,
    input  instr_u          prog_data,
    output instr_u          instr
);

    localparam int DEPTH = 2 ** PC_W;

    instr_u mem [DEPTH];                         // Program store

    // Load port only accepted while idle
    always_ff @(posedge clk) begin
        if (prog_we && !running)
            mem[prog_addr] <= prog_data;
    end

    // NOP keeps the datapath quiet outside a run
    assign instr = running ? mem[pc] : NOP_WORD;

endmodule

`default_nettype wire

// ==== src/program_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module program_counter #(
    parameter int PC_W = 8                       // At least 4 for the offset
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            running,
    input  logic            branch,              // BEQZ in this cycle
    input  logic            zero,                // r1 tested as zero
    input  logic [3:0]      offset,              // Signed, {ra, rb}
    output logic [PC_W-1:0] pc
);

    logic [PC_W-1:0] offset_ext;                 // Sign-extended offset
    logic [PC_W-1:0] pc_seq;                     // Next sequential address

    assign offset_ext = {{(PC_W - 4){offset[3]}}, offset};
    assign pc_seq     = pc + PC_W'(1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (running) begin              // Holds while idle
            if (branch && zero)
                pc <= pc_seq + offset_ext;       // Taken branch
            else
                pc <= pc_seq;
        end
    end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [1:0]        ra,                // Read port a
    input  logic [1:0]        rb,                // Read port b
    input  logic              we,
    input  logic [1:0]        waddr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] data_a,
    output logic [DATA_W-1:0] data_b,
    output logic [DATA_W-1:0] data_r1            // Branch test operand
);

    logic [DATA_W-1:0] regs [4];                 // r0 to r3

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;                // Takes effect at cycle end
        end
    end

    // Combinational reads
    assign data_a  = regs[ra];
    assign data_b  = regs[rb];
    assign data_r1 = regs[R1_ADDR];

endmodule

`default_nettype wire

// ==== src/run_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module run_control #(
    parameter int CYCLE_LIMIT = 4096             // Run cycles before overrun
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic halt,                           // Current instruction is HALT
    output logic running,
    output logic ack,                            // Sticky until reset
    output logic overrun                         // Sticky, only with ack
);

    localparam int CNT_W = $clog2(CYCLE_LIMIT + 1);

    logic             seen_start;                // start has been high
    logic             released;                  // start fell after seen high
    logic [CNT_W-1:0] cycle_cnt;                 // Cycles spent running
    logic             limit_hit;                 // Last allowed run cycle

    assign running   = released & ~ack;          // Drops at the finishing edge
    assign limit_hit = (cycle_cnt == CNT_W'(CYCLE_LIMIT - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seen_start <= 1'b0;
            released   <= 1'b0;
        end else if (!released && !ack) begin   // Start ignored once finished
            if (start)
                seen_start <= 1'b1;
            else if (seen_start)
                released <= 1'b1;                // Release edge starts the run
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle_cnt <= '0;
            ack       <= 1'b0;
            overrun   <= 1'b0;
        end else if (running) begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (halt) begin
                ack <= 1'b1;                     // HALT wins over the limit
            end else if (limit_hit) begin
                ack     <= 1'b1;
                overrun <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
